// File: flist.f
source/icache_pkg.sv
source/way_ram.sv
source/plru_tree.sv
source/icache_ctrl.sv
source/icache_top.sv
tb/icache_properties.sv
tb/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
    -f flist.f -o icache_sim

status=0
./obj_dir/icache_sim > sim.log 2>&1 || status=$?
cat sim.log

# a simulator stop on an assertion counts as a failed run
if [ "$status" -ne 0 ] || ! grep -q "TEST OK" sim.log; then
    grep -q "TEST FAILED" sim.log || echo "TEST FAILED" >> sim.log
fi

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: source/icache_ctrl.sv
// icache_ctrl: lookup, refill and uncached FSM of the instruction cache
// handles the cpu and memory four-phase handshakes and drives the way arrays
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          cpu_req,
    input  logic [icache_pkg::addr_w-1:0]                 cpu_addr,
    input  logic                                          cpu_uncached,
    output logic                                          cpu_ack,
    output logic [icache_pkg::data_w-1:0]                 cpu_rdata,
    output logic                                          mem_req,
    output logic [icache_pkg::addr_w-1:0]                 mem_addr,
    input  logic                                          mem_ack,
    input  logic [icache_pkg::data_w-1:0]                 mem_rdata,
    output icache_pkg::set_idx_t                          ram_index,
    output logic [icache_pkg::way_num-1:0]                tag_we,
    output icache_pkg::tagv_t                             tag_wdata,
    input  icache_pkg::tagv_t [icache_pkg::way_num-1:0]   tag_rdata,
    output logic [icache_pkg::way_num-1:0]                data_we,
    output icache_pkg::line_t                             data_wdata,
    input  icache_pkg::line_t [icache_pkg::way_num-1:0]   data_rdata,
    output logic                                          lru_touch,
    output icache_pkg::set_idx_t                          lru_set,
    output icache_pkg::way_idx_t                          lru_way,
    input  icache_pkg::way_idx_t                          lru_victim
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,      // set read in flight
        S_LOOKUP,    // tag compare
        S_MEM_REQ,   // mem_req high, waiting for mem_ack
        S_MEM_WAIT,  // waiting for mem_ack low
        S_FILL,      // victim way written
        S_UNC,       // uncached word captured
        S_DONE       // cpu_ack high until cpu_req drops
    } state_t;

    state_t state;

    // request buffer
    logic [icache_pkg::addr_w-1:0]     buf_addr;
    logic                              buf_unc;
    logic [icache_pkg::tag_w-1:0]      buf_tag;
    icache_pkg::set_idx_t              buf_index;
    logic [icache_pkg::word_sel_w-1:0] buf_word;

    logic [icache_pkg::word_sel_w-1:0] beat;
    icache_pkg::line_t                 line_buf;

    logic                 hit_any;
    icache_pkg::way_idx_t hit_way;
    icache_pkg::way_idx_t fill_way;

    assign buf_tag   = buf_addr[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign buf_index = buf_addr[icache_pkg::offset_w +: icache_pkg::index_w];
    assign buf_word  = buf_addr[icache_pkg::offset_w - icache_pkg::word_sel_w +:
                                icache_pkg::word_sel_w];

    // one set is active for the whole request
    assign ram_index = buf_index;
    assign lru_set   = buf_index;

    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < icache_pkg::way_num; w++) begin
            if (tag_rdata[w].valid && (tag_rdata[w].tag == buf_tag)) begin
                hit_any = 1'b1;
                hit_way = icache_pkg::way_idx_t'(w);
            end
        end
    end

    // lowest invalid way, else the plru pick
    always_comb begin
        fill_way = lru_victim;
        for (int w = icache_pkg::way_num - 1; w >= 0; w--) begin
            if (!tag_rdata[w].valid) begin
                fill_way = icache_pkg::way_idx_t'(w);
            end
        end
    end

    always_comb begin
        tag_we = '0;
        if (state == S_FILL) begin
            tag_we[fill_way] = 1'b1;
        end
    end

    assign data_we    = tag_we;  // tag and line always written together
    assign tag_wdata  = '{valid: 1'b1, tag: buf_tag};
    assign data_wdata = line_buf;

    assign lru_touch = (state == S_FILL) || ((state == S_LOOKUP) && hit_any);
    assign lru_way   = (state == S_FILL) ? fill_way : hit_way;

    // uncached beats use the word address, refill beats walk the line
    assign mem_req  = (state == S_MEM_REQ);
    assign mem_addr = buf_unc ?
        {buf_addr[icache_pkg::addr_w-1:icache_pkg::offset_w - icache_pkg::word_sel_w],
         {(icache_pkg::offset_w - icache_pkg::word_sel_w){1'b0}}} :
        {buf_tag, buf_index, beat, {(icache_pkg::offset_w - icache_pkg::word_sel_w){1'b0}}};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            cpu_ack <= 1'b0;
            beat    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // previous beat must be fully closed first
                    if (cpu_req && !mem_ack) begin
                        beat  <= '0;
                        state <= cpu_uncached ? S_MEM_REQ : S_READ;
                    end
                end
                S_READ:   state <= S_LOOKUP;
                S_LOOKUP: begin
                    if (hit_any) begin
                        cpu_ack <= 1'b1;
                        state   <= S_DONE;
                    end else begin
                        beat  <= '0;
                        state <= S_MEM_REQ;
                    end
                end
                S_MEM_REQ: begin
                    if (mem_ack) begin
                        state <= buf_unc ? S_UNC : S_MEM_WAIT;
                    end
                end
                S_MEM_WAIT: begin
                    if (!mem_ack) begin
                        beat  <= beat + 1'b1;
                        state <= (beat == icache_pkg::word_sel_w'(icache_pkg::line_words - 1)) ?
                                 S_FILL : S_MEM_REQ;
                    end
                end
                S_FILL: state <= S_READ;  // re-read the set, then hit
                S_UNC: begin
                    cpu_ack <= 1'b1;
                    state   <= S_DONE;
                end
                S_DONE: begin
                    if (!cpu_req) begin
                        cpu_ack <= 1'b0;
                        state   <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if ((state == S_IDLE) && cpu_req) begin
            buf_addr <= cpu_addr;
            buf_unc  <= cpu_uncached;
        end
        if ((state == S_MEM_REQ) && mem_ack) begin
            line_buf[beat] <= mem_rdata;
            if (buf_unc) begin
                cpu_rdata <= mem_rdata;  // uncached word straight to the cpu
            end
        end
        if ((state == S_LOOKUP) && hit_any) begin
            cpu_rdata <= data_rdata[hit_way][buf_word];
        end
    end

endmodule

`default_nettype wire

// File: source/icache_pkg.sv
// icache shared definitions
// cache geometry, address field widths and storage payload types
`default_nettype none

package icache_pkg;

    // geometry
    localparam int unsigned addr_w     = 32;
    localparam int unsigned data_w     = 32;
    localparam int unsigned way_num    = 4;
    localparam int unsigned set_num    = 16;
    localparam int unsigned line_words = 4;

    // address fields, tag | index | word | byte
    localparam int unsigned offset_w   = 4;  // byte within line
    localparam int unsigned index_w    = 4;
    localparam int unsigned tag_w      = addr_w - index_w - offset_w;
    localparam int unsigned word_sel_w = 2;  // word within line

    // one tag way entry
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tagv_t;

    // one data way entry, word 0 in the low bits
    typedef logic [line_words-1:0][data_w-1:0] line_t;

    typedef logic [$clog2(way_num)-1:0] way_idx_t;
    typedef logic [index_w-1:0]         set_idx_t;

endpackage

`default_nettype wire

// File: source/icache_top.sv
// icache_top: four-way read-only instruction cache
// controller, tag and data ways, and the pseudo-LRU state
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cpu_req,
    input  logic                          cpu_uncached,
    input  logic [icache_pkg::addr_w-1:0] cpu_addr,
    output logic                          cpu_ack,
    output logic [icache_pkg::data_w-1:0] cpu_rdata,
    output logic                          mem_req,
    output logic [icache_pkg::addr_w-1:0] mem_addr,
    input  logic                          mem_ack,
    input  logic [icache_pkg::data_w-1:0] mem_rdata
);

    icache_pkg::set_idx_t                          ram_index;
    logic [icache_pkg::way_num-1:0]                tag_we;
    icache_pkg::tagv_t                             tag_wdata;
    icache_pkg::tagv_t [icache_pkg::way_num-1:0]   tag_rdata;
    logic [icache_pkg::way_num-1:0]                data_we;
    icache_pkg::line_t                             data_wdata;
    icache_pkg::line_t [icache_pkg::way_num-1:0]   data_rdata;
    logic                                          lru_touch;
    icache_pkg::set_idx_t                          lru_set;
    icache_pkg::way_idx_t                          lru_way;
    icache_pkg::way_idx_t                          lru_victim;

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .cpu_addr     (cpu_addr),
        .cpu_uncached (cpu_uncached),
        .cpu_ack      (cpu_ack),
        .cpu_rdata    (cpu_rdata),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .ram_index    (ram_index),
        .tag_we       (tag_we),
        .tag_wdata    (tag_wdata),
        .tag_rdata    (tag_rdata),
        .data_we      (data_we),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .lru_touch    (lru_touch),
        .lru_set      (lru_set),
        .lru_way      (lru_way),
        .lru_victim   (lru_victim)
    );

    for (genvar w = 0; w < icache_pkg::way_num; w++) begin : tag_ways
        way_ram #(.dtype(icache_pkg::tagv_t)) u_ram (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (tag_we[w]),
            .addr  (ram_index),
            .wdata (tag_wdata),
            .rdata (tag_rdata[w])
        );
    end

    for (genvar w = 0; w < icache_pkg::way_num; w++) begin : data_ways
        way_ram #(.dtype(icache_pkg::line_t)) u_ram (
            .clk   (clk),
            .rst_n (rst_n),
            .we    (data_we[w]),
            .addr  (ram_index),
            .wdata (data_wdata),
            .rdata (data_rdata[w])
        );
    end

    plru_tree u_plru (
        .clk        (clk),
        .rst_n      (rst_n),
        .touch      (lru_touch),
        .touch_set  (lru_set),
        .touch_way  (lru_way),
        .query_set  (lru_set),
        .victim_way (lru_victim)
    );

endmodule

`default_nettype wire

// File: source/plru_tree.sv
// plru_tree: tree pseudo-LRU state, three bits per set
// touch points the tree away from a way, victim follows the bits from the root
`timescale 1ns/1ps
`default_nettype none

module plru_tree (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 touch,
    input  icache_pkg::set_idx_t touch_set,
    input  icache_pkg::way_idx_t touch_way,
    input  icache_pkg::set_idx_t query_set,
    output icache_pkg::way_idx_t victim_way
);

    // bit 0 root: 0 picks pair {0,1}, 1 picks pair {2,3}
    // bit 1 inside {0,1}, bit 2 inside {2,3}
    logic [2:0] tree [icache_pkg::set_num];
    logic [2:0] q_bits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < icache_pkg::set_num; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (touch) begin
            tree[touch_set][0] <= ~touch_way[1];  // other pair next
            if (touch_way[1]) begin
                tree[touch_set][2] <= ~touch_way[0];
            end else begin
                tree[touch_set][1] <= ~touch_way[0];
            end
        end
    end

    assign q_bits = tree[query_set];

    always_comb begin
        if (q_bits[0]) begin
            victim_way = {1'b1, q_bits[2]};
        end else begin
            victim_way = {1'b0, q_bits[1]};
        end
    end

endmodule

`default_nettype wire

// File: source/way_ram.sv
// way_ram: storage for one cache way, one entry per set
// registered read, write-first when the written entry is also read
`timescale 1ns/1ps
`default_nettype none

module way_ram #(
    parameter type dtype = logic
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 we,
    input  icache_pkg::set_idx_t addr,
    input  dtype                 wdata,
    output dtype                 rdata
);

    dtype mem [icache_pkg::set_num];

    // cleared on reset so every valid bit starts low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < icache_pkg::set_num; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (we) begin
                mem[addr] <= wdata;
                rdata     <= wdata;  // new data visible next cycle
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/icache_properties.sv
// icache controller handshake and write-enable assertions
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           cpu_req,
    input logic                           cpu_ack,
    input logic                           mem_req,
    input logic [icache_pkg::addr_w-1:0]  mem_addr,
    input logic                           mem_ack,
    input logic [icache_pkg::way_num-1:0] tag_we
);

    ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_ack) |-> $past(cpu_req))
        else $error("cpu_ack rose without a pending cpu_req");

    ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cpu_ack) |-> !$past(cpu_req))
        else $error("cpu_ack fell while cpu_req was still high");

    // request held with its address until the memory answers
    mem_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr)))
        else $error("mem_req or mem_addr changed before mem_ack");

    // at most one way, and only just after the closing refill beat
    we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(tag_we) && ((tag_we == '0) || ($past(mem_ack, 2) && !$past(mem_ack))))
        else $error("tag write outside a refill or to more than one way");

endmodule

bind icache_ctrl icache_properties u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .cpu_req  (cpu_req),
    .cpu_ack  (cpu_ack),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_ack  (mem_ack),
    .tag_we   (tag_we)
);

`default_nettype wire

// File: tb/icache_tb.sv
// icache testbench
// cpu reads against a randomly delayed memory, checks data, beat counts and hit latency
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    logic                          clk;
    logic                          rst_n;
    logic                          cpu_req;
    logic                          cpu_uncached;
    logic [icache_pkg::addr_w-1:0] cpu_addr;
    logic                          cpu_ack;
    logic [icache_pkg::data_w-1:0] cpu_rdata;
    logic                          mem_req;
    logic [icache_pkg::addr_w-1:0] mem_addr;
    logic                          mem_ack;
    logic [icache_pkg::data_w-1:0] mem_rdata;

    integer      seed = 32'h6e4fc0eb;
    int          beat_cnt;
    logic [31:0] beat_addrs [$];  // addresses of the beats of the current read
    int          delay_left;
    logic        delay_armed;
    int          checks;
    int          errors;
    int          test_errors;
    int          test_num;
    logic        timed_out;

    // cache model, four ways per set plus the tree bits
    logic        mdl_valid [16][4];
    logic [23:0] mdl_tag   [16][4];
    logic [2:0]  mdl_plru  [16];

    // set 5 sequence A..E, then B, A, C
    int repl_line  [8] = '{1, 2, 3, 4, 5, 2, 1, 3};
    int repl_beats [8] = '{4, 4, 4, 4, 4, 0, 4, 4};

    icache_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .cpu_uncached (cpu_uncached),
        .cpu_addr     (cpu_addr),
        .cpu_ack      (cpu_ack),
        .cpu_rdata    (cpu_rdata),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // memory contents, a fixed mixing of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] w;
        w = {addr[31:2], 2'b00};
        return (w * 32'h9e3779b1) ^ {w[12:0], w[31:13]} ^ 32'h5a5a_0f0f;
    endfunction

    // memory side, one word per handshake after 0 to 3 cycles
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_ack     = 1'b0;
            delay_armed = 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) begin
                mem_ack = 1'b0;
            end
        end else if (mem_req) begin
            if (!delay_armed) begin
                delay_left  = $unsigned($random(seed)) % 4;
                delay_armed = 1'b1;
            end
            if (delay_left == 0) begin
                mem_rdata   = mem_word(mem_addr);
                mem_ack     = 1'b1;
                delay_armed = 1'b0;
                beat_cnt++;
                beat_addrs.push_back(mem_addr);
            end else begin
                delay_left--;
            end
        end
    end

    // tree bits point away from the touched way
    function automatic void touch_model(input int set, input int way);
        mdl_plru[set][0] = (way < 2);
        if (way >= 2) begin
            mdl_plru[set][2] = (way == 2);
        end else begin
            mdl_plru[set][1] = (way == 0);
        end
    endfunction

    // predicted beats of one read, 0 hit, 1 uncached, 4 refill
    function automatic int model_access(input logic [31:0] addr, input logic unc);
        int set;
        int way;
        set = int'(addr[7:4]);
        way = -1;
        if (unc) begin
            return 1;
        end
        for (int w = 0; w < 4; w++) begin
            if (mdl_valid[set][w] && (mdl_tag[set][w] == addr[31:8])) way = w;
        end
        if (way >= 0) begin
            touch_model(set, way);
            return 0;
        end
        for (int w = 3; w >= 0; w--) begin
            if (!mdl_valid[set][w]) way = w;  // lowest invalid way wins
        end
        if (way < 0) begin
            way = mdl_plru[set][0] ? 2 + int'(mdl_plru[set][2]) : int'(mdl_plru[set][1]);
        end
        mdl_valid[set][way] = 1'b1;
        mdl_tag[set][way]   = addr[31:8];
        touch_model(set, way);
        return 4;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (!timed_out) begin
            checks++;
            if (got !== exp) begin
                $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
                errors++;
                test_errors++;
            end
        end
    endtask

    task automatic note_timeout(input string what);
        $display("timeout: %s", what);
        timed_out = 1'b1;
        errors++;
        test_errors++;
    endtask

    // one four-phase read, returns beats seen and falling edges until ack
    task automatic cpu_read(input logic [31:0] addr, input logic unc,
                            output int beats, output int lat);
        int n;
        beats = 0;
        lat   = 0;
        if (!timed_out) begin
            beat_cnt = 0;
            beat_addrs.delete();
            cpu_addr     = addr;
            cpu_uncached = unc;
            cpu_req      = 1'b1;
            n = 0;
            while (!cpu_ack && n < 100) begin
                @(negedge clk);
                n++;
            end
            if (!cpu_ack) begin
                note_timeout("no cpu_ack for a read request");
            end else begin
                lat   = n;
                beats = beat_cnt;
                check("cpu_rdata", cpu_rdata, mem_word(addr));
                cpu_req = 1'b0;
                n = 0;
                while (cpu_ack && n < 10) begin
                    @(negedge clk);
                    n++;
                end
                if (cpu_ack) note_timeout("cpu_ack stayed high after cpu_req dropped");
            end
        end
    endtask

    // exp_beats below zero takes the model's prediction
    task automatic read_expect(input logic [31:0] addr, input logic unc,
                               input int exp_beats, output int lat);
        int predicted;
        int beats;
        predicted = model_access(addr, unc);
        cpu_read(addr, unc, beats, lat);
        check("beat_count", beats, (exp_beats < 0) ? predicted : exp_beats);
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %s", test_num, name, (test_errors == 0) ? "pass" : "fail");
        test_errors = 0;
    endtask

    initial begin
        int          lat;
        logic [31:0] r;
        logic [31:0] a;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        test_num     = 0;
        timed_out    = 1'b0;
        beat_cnt     = 0;
        cpu_req      = 1'b0;
        cpu_uncached = 1'b0;
        cpu_addr     = '0;
        mem_ack      = 1'b0;
        mem_rdata    = '0;
        rst_n        = 1'b0;
        for (int s = 0; s < 16; s++) begin
            mdl_plru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                mdl_valid[s][w] = 1'b0;
                mdl_tag[s][w]   = '0;
            end
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        read_expect(32'h0000_0124, 1'b0, 4, lat);  // cold miss, refill from the base
        for (int i = 0; i < beat_addrs.size(); i++) begin
            check("mem_addr", beat_addrs[i], 32'h0000_0120 + 32'(4 * i));
        end
        read_expect(32'h0000_0120, 1'b0, 0, lat);
        read_expect(32'h0000_0128, 1'b0, 0, lat);
        read_expect(32'h0000_012c, 1'b0, 0, lat);
        end_test("cold miss then hit");

        // ack two rising edges after the sampling edge, seen on the third falling edge
        read_expect(32'h0000_0128, 1'b0, 0, lat);
        check("hit_latency", lat, 3);
        end_test("hit latency");

        repeat (2) begin
            read_expect(32'h0000_0234, 1'b1, 1, lat);
            if (beat_addrs.size() > 0) check("mem_addr", beat_addrs[0], 32'h0000_0234);
        end
        read_expect(32'h0000_0234, 1'b0, 4, lat);  // nothing was stored
        end_test("uncached path");

        for (int i = 0; i < 8; i++) begin
            read_expect({16'h0000, 4'(repl_line[i]), 12'h050}, 1'b0, repl_beats[i], lat);
        end
        end_test("replacement");

        // tags 0..7 over sets 0..3, about a quarter uncached
        for (int i = 0; i < 200; i++) begin
            r = $random(seed);
            a = {21'd0, r[10:8], 2'b00, r[5:4], r[3:2], 2'b00};
            read_expect(a, r[17:16] == 2'b00, -1, lat);
        end
        end_test("random mix");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
